/* build.f */
+incdir+tests
design/reverb_pkg.sv
design/record_impulse.sv
design/ir_memory.sv
design/convolve_audio.sv
design/reverb_top.sv
tests/reverb_tb.sv

/* design/convolve_audio.sv */
`timescale 1ns/1ps

module convolve_audio (
  input  logic                                   audio_clk,
  input  logic                                   rst_in,
  input  logic                                   audio_trigger,
  input  reverb_pkg::sample_t                    audio_in,
  input  logic                                   impulse_recorded,
  output logic [reverb_pkg::WORD_ADDR_WIDTH-1:0] rd_word,
  input  reverb_pkg::ir_taps_t                   rd_taps,
  output logic signed [reverb_pkg::ACC_WIDTH-1:0] convolution_result,
  output logic                                   result_valid
);
  import reverb_pkg::*;

  sample_t hist [IR_LENGTH];  // hist[k] is x[n-k] once shifted

  // read issue stage
  logic                       busy;
  logic [WORD_ADDR_WIDTH-1:0] word_cnt;

  // memory return stage
  logic                       rd_valid;
  logic                       rd_last;
  logic [WORD_ADDR_WIDTH-1:0] rd_idx;  // word that rd_taps belongs to

  logic signed [2*SAMPLE_WIDTH-1:0] prod [TAPS_PER_READ];
  logic signed [ACC_WIDTH-1:0]      partial;
  logic signed [ACC_WIDTH-1:0]      acc;

  assign rd_word = word_cnt;

  // input history, shifts on every strobe
  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      for (int k = 0; k < IR_LENGTH; k++) begin
        hist[k] <= '0;
      end
    end else if (audio_trigger) begin
      hist[0] <= audio_in;
      for (int k = 1; k < IR_LENGTH; k++) begin
        hist[k] <= hist[k-1];
      end
    end
  end

  // four taps against the matching history entries
  always_comb begin
    partial = '0;
    for (int i = 0; i < TAPS_PER_READ; i++) begin
      prod[i] = $signed(rd_taps.tap[i]) * hist[TAPS_PER_READ * rd_idx + i];
      partial = partial + prod[i];  // sign extended to ACC_WIDTH
    end
  end

  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      busy         <= 1'b0;
      word_cnt     <= '0;
      rd_valid     <= 1'b0;
      rd_last      <= 1'b0;
      acc          <= '0;
      result_valid <= 1'b0;
    end else begin
      rd_valid     <= busy;
      rd_last      <= busy && (word_cnt == WORD_ADDR_WIDTH'(IR_WORDS - 1));
      result_valid <= 1'b0;

      if (audio_trigger && impulse_recorded) begin
        busy     <= 1'b1;
        word_cnt <= '0;
      end else if (busy) begin
        word_cnt <= word_cnt + 1'b1;
        if (word_cnt == WORD_ADDR_WIDTH'(IR_WORDS - 1)) busy <= 1'b0;
      end

      if (rd_valid) begin
        if (rd_last) begin
          acc          <= '0;  // ready for next sample
          result_valid <= 1'b1;
        end else begin
          acc <= acc + partial;
        end
      end
    end
  end

  // payload side, no reset
  always_ff @(posedge audio_clk) begin
    rd_idx <= word_cnt;
    if (rd_valid && rd_last) begin
      convolution_result <= acc + partial;
    end
  end

  // strobes must be spaced so a sum finishes before the history moves
  a_no_trigger_busy: assert property (@(posedge audio_clk) disable iff (rst_in)
    audio_trigger |-> !busy);

  a_valid_one_cycle: assert property (@(posedge audio_clk) disable iff (rst_in)
    result_valid |=> !result_valid);

endmodule

/* design/ir_memory.sv */
`timescale 1ns/1ps

module ir_memory (
  input  logic                                   audio_clk,
  input  logic                                   rst_in,
  input  reverb_pkg::ir_write_t                  ir_wr,
  input  logic [reverb_pkg::WORD_ADDR_WIDTH-1:0] rd_word,
  output reverb_pkg::ir_taps_t                   rd_taps
);
  import reverb_pkg::*;

  // one sample per tap
  sample_t mem [IR_LENGTH];

  // single-sample write port
  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      for (int i = 0; i < IR_LENGTH; i++) begin
        mem[i] <= '0;
      end
    end else if (ir_wr.en) begin
      mem[ir_wr.addr] <= ir_wr.sample;
    end
  end

  // read port
  // a word covers TAPS_PER_READ adjacent taps starting at rd_word * TAPS_PER_READ
  always_ff @(posedge audio_clk) begin
    for (int i = 0; i < TAPS_PER_READ; i++) begin
      rd_taps.tap[i] <= mem[TAPS_PER_READ * rd_word + i];
    end
  end

  // an enabled write lands on a defined tap with a defined sample
  a_wr_addr_range: assert property (@(posedge audio_clk) disable iff (rst_in)
    ir_wr.en |-> !$isunknown({ir_wr.addr, ir_wr.sample}));

endmodule

/* design/record_impulse.sv */
`timescale 1ns/1ps

module record_impulse (
  input  logic                               audio_clk,
  input  logic                               rst_in,
  input  logic                               audio_trigger,
  input  logic                               record_trigger,
  input  logic [reverb_pkg::DELAY_WIDTH-1:0] delay_length,
  input  reverb_pkg::sample_t                audio_in,
  output reverb_pkg::ir_write_t              ir_wr,
  output logic                               impulse_recorded
);
  import reverb_pkg::*;

  typedef enum logic [1:0] {
    idle,
    waiting,
    capturing
  } state_t;

  state_t                   state;
  logic [DELAY_WIDTH-1:0]   delay_cnt;  // strobes left to skip
  logic [IR_ADDR_WIDTH-1:0] tap_cnt;    // next tap to write
  logic                     last_write;

  // final tap is being written this cycle
  assign last_write = ir_wr.en && (ir_wr.addr == IR_ADDR_WIDTH'(IR_LENGTH - 1));

  always_ff @(posedge audio_clk) begin
    // write payload follows every strobe, only en qualifies it
    if (audio_trigger) begin
      ir_wr.addr   <= tap_cnt;
      ir_wr.sample <= audio_in;
    end

    if (rst_in) begin
      state            <= idle;
      delay_cnt        <= '0;
      tap_cnt          <= '0;
      ir_wr.en         <= 1'b0;
      impulse_recorded <= 1'b0;
    end else begin
      ir_wr.en <= 1'b0;
      case (state)
        idle: begin
          if (record_trigger) begin
            impulse_recorded <= 1'b0;  // old response no longer valid
            delay_cnt        <= delay_length;
            tap_cnt          <= '0;
            state            <= (delay_length == '0) ? capturing : waiting;
          end
        end
        waiting: begin
          if (audio_trigger) begin
            delay_cnt <= delay_cnt - 1'b1;
            if (delay_cnt == DELAY_WIDTH'(1)) state <= capturing;
          end
        end
        capturing: begin
          // stay here until the last write has landed
          if (last_write) begin
            state            <= idle;
            impulse_recorded <= 1'b1;
          end else if (audio_trigger) begin
            ir_wr.en <= 1'b1;
            tap_cnt  <= tap_cnt + 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // memory is only written during a capture
  a_no_write_idle: assert property (@(posedge audio_clk) disable iff (rst_in)
    (state == idle) |-> !ir_wr.en);

  // recorded flag only comes up right after the final tap
  a_recorded_after_capture: assert property (@(posedge audio_clk) disable iff (rst_in)
    $rose(impulse_recorded) |-> $past(last_write && (state == capturing)));

endmodule

/* design/reverb_pkg.sv */
package reverb_pkg;

  // audio sample format
  localparam int SAMPLE_WIDTH = 16;

  // impulse response geometry
  localparam int IR_LENGTH = 16;
  localparam int TAPS_PER_READ = 4;
  localparam int IR_WORDS = IR_LENGTH / TAPS_PER_READ;
  localparam int IR_ADDR_WIDTH = $clog2(IR_LENGTH);
  localparam int WORD_ADDR_WIDTH = $clog2(IR_WORDS);

  // 16 products of 32 bits, plus headroom
  localparam int ACC_WIDTH = 40;

  localparam int DELAY_WIDTH = 8;

  // strobe to result strobe: word reads, then memory and accumulate stages
  localparam int CONV_LATENCY = IR_WORDS + 2;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // one write into the tap memory
  typedef struct packed {
    logic                     en;
    logic [IR_ADDR_WIDTH-1:0] addr;   // tap index
    sample_t                  sample;
  } ir_write_t;

  // one read word, tap 0 in the low bits
  typedef struct packed {
    sample_t [TAPS_PER_READ-1:0] tap;
  } ir_taps_t;

endpackage

/* design/reverb_top.sv */
`timescale 1ns/1ps

module reverb_top (
  input  logic                                    audio_clk,
  input  logic                                    rst_in,
  input  logic                                    audio_trigger,
  input  logic                                    record_trigger,
  input  logic [reverb_pkg::DELAY_WIDTH-1:0]      delay_length,
  input  reverb_pkg::sample_t                     audio_in,
  output logic                                    impulse_recorded,
  output logic signed [reverb_pkg::ACC_WIDTH-1:0] convolution_result,
  output logic                                    result_valid
);
  import reverb_pkg::*;

  ir_write_t                  ir_wr;    // recorder into tap memory
  logic [WORD_ADDR_WIDTH-1:0] rd_word;
  ir_taps_t                   rd_taps;

  // producer
  record_impulse u_record (
    .audio_clk        (audio_clk),
    .rst_in           (rst_in),
    .audio_trigger    (audio_trigger),
    .record_trigger   (record_trigger),
    .delay_length     (delay_length),
    .audio_in         (audio_in),
    .ir_wr            (ir_wr),
    .impulse_recorded (impulse_recorded)
  );

  // tap storage
  ir_memory u_memory (
    .audio_clk (audio_clk),
    .rst_in    (rst_in),
    .ir_wr     (ir_wr),
    .rd_word   (rd_word),
    .rd_taps   (rd_taps)
  );

  // consumer
  convolve_audio u_convolve (
    .audio_clk          (audio_clk),
    .rst_in             (rst_in),
    .audio_trigger      (audio_trigger),
    .audio_in           (audio_in),
    .impulse_recorded   (impulse_recorded),
    .rd_word            (rd_word),
    .rd_taps            (rd_taps),
    .convolution_result (convolution_result),
    .result_valid       (result_valid)
  );

endmodule

/* tests/reverb_ref.svh */
`ifndef REVERB_REF_SVH
`define REVERB_REF_SVH

// model_hist[k] holds x[n-k]
sample_t model_hist [IR_LENGTH];
// taps as captured from the stimulus
sample_t model_ir [IR_LENGTH];

// both models start out zero, as after reset
function automatic void clear_models();
  for (int k = 0; k < IR_LENGTH; k++) begin
    model_hist[k] = '0;
    model_ir[k]   = '0;
  end
endfunction

// every strobe moves the history, recorded or not
function automatic void shift_history(input sample_t value);
  for (int k = IR_LENGTH - 1; k > 0; k--) begin
    model_hist[k] = model_hist[k-1];
  end
  model_hist[0] = value;
endfunction

// sum of h[k] * x[n-k] over all taps, wide enough that nothing wraps
function automatic logic signed [ACC_WIDTH-1:0] conv_reference();
  longint sum;
  sum = 0;
  for (int k = 0; k < IR_LENGTH; k++) begin
    sum += longint'(model_ir[k]) * longint'(model_hist[k]);
  end
  return ACC_WIDTH'(sum);
endfunction

`endif

/* tests/reverb_tb.sv */
`timescale 1ns/1ps

module reverb_tb;
  import reverb_pkg::*;

  `include "reverb_ref.svh"

  localparam int strobe_gap    = 12;   // cycles between audio strobes
  localparam int total_strobes = 214;  // summed over the six tests
  localparam int watchdog_ns   = (total_strobes * strobe_gap * 100 + 10 * 100) * 2;

  typedef enum {model_idle, model_waiting, model_capturing} phase_t;

  // one result the compare process still waits for
  typedef struct packed {
    logic [63:0]                 due;    // negedge time the strobe is expected
    logic signed [ACC_WIDTH-1:0] value;
  } pending_t;

  logic                        audio_clk;
  logic                        rst_in;
  logic                        audio_trigger;
  logic                        record_trigger;
  logic [DELAY_WIDTH-1:0]      delay_length;
  sample_t                     audio_in;
  logic                        impulse_recorded;
  logic signed [ACC_WIDTH-1:0] convolution_result;
  logic                        result_valid;

  pending_t pending_q [$];
  integer   seed;
  phase_t   model_phase;
  logic     model_recorded;
  int       wait_left;
  int       tap_next;
  int       error_count;
  int       check_count;
  int       test_count;
  int       failed_tests;
  int       errors_at_start;

  reverb_top UUT (
    .audio_clk          (audio_clk),
    .rst_in             (rst_in),
    .audio_trigger      (audio_trigger),
    .record_trigger     (record_trigger),
    .delay_length       (delay_length),
    .audio_in           (audio_in),
    .impulse_recorded   (impulse_recorded),
    .convolution_result (convolution_result),
    .result_valid       (result_valid)
  );

  initial audio_clk = 1'b0;
  always #50 audio_clk = ~audio_clk;

  task automatic check_value(input string name, input logic [ACC_WIDTH-1:0] expected,
                             input logic [ACC_WIDTH-1:0] actual);
    check_count++;
    if (actual !== expected) begin
      $display("Fail %s: expected %h, got %h", name, expected, actual);
      error_count++;
    end
  endtask

  function automatic sample_t random_sample();
    return sample_t'($random(seed));
  endfunction

  // one strobe and the idle cycles up to the next slot
  task automatic send_sample(input sample_t value);
    @(negedge audio_clk);
    check_value("impulse_recorded", model_recorded, impulse_recorded);
    audio_trigger = 1'b1;
    audio_in      = value;
    shift_history(value);
    if (model_recorded) begin
      pending_q.push_back(pending_t'{due: $time + CONV_LATENCY * 100,
                                     value: conv_reference()});
    end
    case (model_phase)
      model_waiting: begin
        wait_left--;
        if (wait_left == 0) model_phase = model_capturing;
      end
      model_capturing: begin
        model_ir[tap_next] = value;
        tap_next++;
        if (tap_next == IR_LENGTH) begin
          model_phase    = model_idle;
          model_recorded = 1'b1;  // response complete
        end
      end
      default: ;
    endcase
    @(negedge audio_clk);
    audio_trigger = 1'b0;
    repeat (strobe_gap - 2) @(negedge audio_clk);
  endtask

  // record pulse between strobes that only an idle recorder accepts
  task automatic start_record(input logic [DELAY_WIDTH-1:0] delay);
    @(negedge audio_clk);
    check_value("impulse_recorded", model_recorded, impulse_recorded);
    record_trigger = 1'b1;
    delay_length   = delay;
    if (model_phase == model_idle) begin
      model_recorded = 1'b0;
      wait_left      = delay;
      tap_next       = 0;
      model_phase    = (delay == 0) ? model_capturing : model_waiting;
    end
    @(negedge audio_clk);
    record_trigger = 1'b0;
    check_value("impulse_recorded", 1'b0, impulse_recorded);  // low one cycle after
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (error_count == errors_at_start) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d errors", test_count, name, error_count - errors_at_start);
      failed_tests++;
    end
    errors_at_start = error_count;
  endtask

  // compare process on the falling edge where outputs are stable
  always @(negedge audio_clk) begin
    if (!rst_in) begin
      if (result_valid) begin
        if (pending_q.size() == 0 || pending_q[0].due != $time) begin
          $display("result_valid at %0t ns with no result expected", $time);
          error_count++;
        end else begin
          check_value("convolution_result", pending_q[0].value, convolution_result);
          void'(pending_q.pop_front());
        end
      end else if (pending_q.size() != 0 && pending_q[0].due <= $time) begin
        $display("result_valid missing %0d cycles after a recorded strobe", CONV_LATENCY);
        error_count++;
        void'(pending_q.pop_front());
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog: run did not finish within %0d ns", watchdog_ns);
    $display("tests failed");
    $finish;
  end

  initial begin
    seed           = 32'hd737_e418;
    rst_in         = 1'b1;
    audio_trigger  = 1'b0;
    record_trigger = 1'b0;
    delay_length   = '0;
    audio_in       = '0;
    model_phase    = model_idle;
    model_recorded = 1'b0;
    wait_left      = 0;
    tap_next       = 0;
    error_count    = 0;
    check_count    = 0;
    test_count     = 0;
    failed_tests   = 0;
    errors_at_start = 0;
    clear_models();
    repeat (10) @(negedge audio_clk);
    rst_in = 1'b0;

    repeat (20) send_sample(random_sample());
    end_test("no results before a recording");

    start_record(8'd0);
    send_sample(16'sd16384);  // unit impulse
    repeat (IR_LENGTH - 1) send_sample('0);
    repeat (20) send_sample(random_sample());
    end_test("unit impulse, delay 0");

    start_record(8'd5);
    repeat (5 + IR_LENGTH) send_sample(random_sample());
    repeat (40) send_sample(random_sample());
    end_test("random impulse, delay 5");

    start_record(8'd3);
    repeat (2) send_sample(random_sample());
    start_record(8'd7);  // during the wait
    repeat (8) send_sample(random_sample());
    start_record(8'd0);  // during the capture
    repeat (9) send_sample(random_sample());
    repeat (4) send_sample(random_sample());
    end_test("record trigger ignored while busy");

    start_record(8'd2);
    repeat (2 + IR_LENGTH) send_sample(random_sample());
    repeat (20) send_sample(random_sample());
    end_test("re-recording a new impulse");

    start_record(8'd0);
    repeat (IR_LENGTH) send_sample(16'h8000);  // most negative sample
    repeat (20) send_sample(16'h8000);
    end_test("full-scale negative samples");

    if (pending_q.size() != 0) begin
      $display("%0d expected results never arrived", pending_q.size());
      error_count++;
    end
    $display("tests run %0d, tests with errors %0d, checks %0d, errors %0d",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
